//--- rvIsaPkg.sv
package rvIsaPkg;

    // Major opcodes
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;

    // ALU funct3 codes, shared by register and immediate forms
    localparam logic [2:0] F3Add  = 3'b000;
    localparam logic [2:0] F3Sll  = 3'b001;
    localparam logic [2:0] F3Slt  = 3'b010;
    localparam logic [2:0] F3Sltu = 3'b011;
    localparam logic [2:0] F3Xor  = 3'b100;
    localparam logic [2:0] F3Srl  = 3'b101;
    localparam logic [2:0] F3Or   = 3'b110;
    localparam logic [2:0] F3And  = 3'b111;

    // Branch funct3 codes
    localparam logic [2:0] F3Beq  = 3'b000;
    localparam logic [2:0] F3Bne  = 3'b001;
    localparam logic [2:0] F3Blt  = 3'b100;
    localparam logic [2:0] F3Bge  = 3'b101;
    localparam logic [2:0] F3Bltu = 3'b110;
    localparam logic [2:0] F3Bgeu = 3'b111;

    localparam logic [6:0] Funct7Alt = 7'b0100000; // SUB, SRA, SRAI

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instrFields;

endpackage

//--- rvCorePkg.sv
package rvCorePkg;

    localparam int Xlen        = 32;
    localparam int MemWords    = 256;
    localparam int MemAddrBits = $clog2(MemWords); // Word index width

    typedef enum logic [1:0] {
        Fetch,
        Decode,
        Execute,
        Writeback
    } phaseT;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSltu,
        AluSll,
        AluSrl,
        AluSra
    } aluOpT;

    typedef enum logic {SrcAPc, SrcARs1} srcASelT;

    typedef enum logic [1:0] {SrcBRs2, SrcBImm, SrcBFour} srcBSelT;

    typedef enum logic [1:0] {ImmI, ImmS, ImmB, ImmJ} immKindT;

    typedef enum logic [1:0] {WbAlu, WbMem, WbPc4} wbSelT;

    typedef struct packed {
        logic    irLoad;
        logic    pcWrite;
        logic    pcFromAlu; // Target instead of pc+4
        srcASelT srcA;
        srcBSelT srcB;
        aluOpT   aluOp;
        immKindT immKind;
        logic    regWrite;
        logic    memWrite;
        wbSelT   wbSel;
        logic    commit;
    } ctrlWord;

    typedef struct packed {
        logic            valid;
        logic [Xlen-1:0] pc;
        logic            rdWrite;
        logic [4:0]      rd;
        logic [Xlen-1:0] rdData;
        logic            memWrite;
        logic [Xlen-1:0] memAddr;
    } commitInfo;

endpackage

//--- rvMemory.sv
`timescale 1ns/100ps

module rvMemory #(
    parameter int Depth = 256
) (
    input  logic                          clk,
    input  logic                          writeEn,
    input  logic [$clog2(Depth)-1:0]      writeAddr,
    input  logic [rvCorePkg::Xlen-1:0]    writeData,
    input  logic [$clog2(Depth)-1:0]      readAddr,
    output logic [rvCorePkg::Xlen-1:0]    readData
);

    logic [rvCorePkg::Xlen-1:0] mem [Depth];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
    end

    assign readData = mem[readAddr]; // Asynchronous read

endmodule

//--- rvImmGen.sv
`timescale 1ns/100ps

module rvImmGen (
    input  rvIsaPkg::instrFields          instr,
    input  rvCorePkg::immKindT            kind,
    output logic [rvCorePkg::Xlen-1:0]    imm
);
    import rvCorePkg::*;

    logic [31:0] raw;

    assign raw = instr;

    always_comb begin
        case (kind)
            ImmS: begin
                imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
            end
            ImmB: begin
                imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
            end
            ImmJ: begin
                imm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
            end
            default: begin
                imm = {{20{raw[31]}}, raw[31:20]}; // I format, shifts too
            end
        endcase
    end

endmodule

//--- rvRegFile.sv
`timescale 1ns/100ps

module rvRegFile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [4:0]                    rs1,
    input  logic [4:0]                    rs2,
    input  logic                          writeEn,
    input  logic [4:0]                    rd,
    input  logic [rvCorePkg::Xlen-1:0]    writeData,
    output logic [rvCorePkg::Xlen-1:0]    rs1Data,
    output logic [rvCorePkg::Xlen-1:0]    rs2Data
);

    logic [rvCorePkg::Xlen-1:0] regs [1:31]; // No storage for x0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rd != 5'd0) begin
            regs[rd] <= writeData;
        end
    end

    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- rvControl.sv
`timescale 1ns/100ps

module rvControl (
    input  logic                 clk,
    input  logic                 reset,
    input  rvIsaPkg::instrFields instr,
    input  logic                 branchTaken,
    output rvCorePkg::ctrlWord   ctrl
);
    import rvIsaPkg::*;
    import rvCorePkg::*;

    phaseT phase;
    logic  alt;
    logic  regUse;
    logic  memUse;
    logic  jump;
    logic  branch;
    logic  wbPhase;

    function automatic aluOpT aluFromFunct3(input logic [2:0] funct3, input logic altOp);
        aluOpT op;
        op = AluAdd;
        case (funct3)
            F3Add:  op = altOp ? AluSub : AluAdd;
            F3Sll:  op = AluSll;
            F3Slt:  op = AluSlt;
            F3Sltu: op = AluSltu;
            F3Xor:  op = AluXor;
            F3Srl:  op = altOp ? AluSra : AluSrl;
            F3Or:   op = AluOr;
            F3And:  op = AluAnd;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= Fetch;
        end else begin
            case (phase)
                Fetch:   phase <= Decode;
                Decode:  phase <= Execute;
                Execute: phase <= Writeback;
                default: phase <= Fetch;
            endcase
        end
    end

    assign alt     = (instr.funct7 == Funct7Alt);
    assign wbPhase = (phase == Writeback);

    always_comb begin
        ctrl         = '0;
        ctrl.srcA    = SrcARs1;
        ctrl.srcB    = SrcBFour; // ALU result unused for unknown opcodes
        ctrl.aluOp   = AluAdd;
        ctrl.immKind = ImmI;
        ctrl.wbSel   = WbAlu;
        regUse       = 1'b0;
        memUse       = 1'b0;
        jump         = 1'b0;
        branch       = 1'b0;
        case (instr.opcode)
            OpReg: begin
                ctrl.srcB  = SrcBRs2;
                ctrl.aluOp = aluFromFunct3(instr.funct3, alt);
                regUse     = 1'b1;
            end
            OpImm: begin
                ctrl.srcB  = SrcBImm;
                ctrl.aluOp = aluFromFunct3(instr.funct3, alt && instr.funct3 == F3Srl);
                regUse     = 1'b1;
            end
            OpLoad: begin
                ctrl.srcB  = SrcBImm;
                ctrl.wbSel = WbMem;
                regUse     = 1'b1;
            end
            OpStore: begin
                ctrl.srcB    = SrcBImm;
                ctrl.immKind = ImmS;
                memUse       = 1'b1;
            end
            OpBranch: begin
                ctrl.srcA    = SrcAPc; // ALU forms the branch target
                ctrl.srcB    = SrcBImm;
                ctrl.immKind = ImmB;
                branch       = 1'b1;
            end
            OpJal: begin
                ctrl.srcA    = SrcAPc;
                ctrl.srcB    = SrcBImm;
                ctrl.immKind = ImmJ;
                ctrl.wbSel   = WbPc4;
                regUse       = 1'b1;
                jump         = 1'b1;
            end
            OpJalr: begin
                ctrl.srcB  = SrcBImm;
                ctrl.wbSel = WbPc4;
                regUse     = 1'b1;
                jump       = 1'b1;
            end
            default: ;
        endcase

        ctrl.irLoad    = (phase == Fetch);
        ctrl.pcWrite   = wbPhase;
        ctrl.pcFromAlu = wbPhase && (jump || (branch && branchTaken));
        ctrl.regWrite  = wbPhase && regUse;
        ctrl.memWrite  = wbPhase && memUse;
        ctrl.commit    = wbPhase; // No-ops retire as well
    end

endmodule

//--- rvFetch.sv
`timescale 1ns/100ps

module rvFetch (
    input  logic                          clk,
    input  logic                          reset,
    input  rvCorePkg::ctrlWord            ctrl,
    input  logic [rvCorePkg::Xlen-1:0]    instrWord,
    input  logic [rvCorePkg::Xlen-1:0]    target,
    output logic [rvCorePkg::Xlen-1:0]    pc,
    output rvIsaPkg::instrFields          instr
);

    // PC also serves as the instruction memory address, sliced at the top
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pcWrite) begin
            if (ctrl.pcFromAlu) begin
                pc <= {target[rvCorePkg::Xlen-1:1], 1'b0}; // JALR drops bit 0
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0; // Opcode 0 decodes as a no-op
        end else if (ctrl.irLoad) begin
            instr <= instrWord;
        end
    end

endmodule

//--- rvExecute.sv
`timescale 1ns/100ps

module rvExecute (
    input  logic                          clk,
    input  logic                          reset,
    input  rvCorePkg::ctrlWord            ctrl,
    input  rvIsaPkg::instrFields          instr,
    input  logic [rvCorePkg::Xlen-1:0]    pc,
    input  logic [rvCorePkg::Xlen-1:0]    imm,
    input  logic [rvCorePkg::Xlen-1:0]    rs1Data,
    input  logic [rvCorePkg::Xlen-1:0]    rs2Data,
    input  logic [rvCorePkg::Xlen-1:0]    memData,
    output logic                          branchTaken,
    output logic [rvCorePkg::Xlen-1:0]    result,
    output logic [rvCorePkg::Xlen-1:0]    storeData,
    output logic [rvCorePkg::Xlen-1:0]    wbData,
    output rvCorePkg::commitInfo          commit
);
    import rvIsaPkg::*;
    import rvCorePkg::*;

    logic [Xlen-1:0] rs1Reg;
    logic [Xlen-1:0] rs2Reg;
    logic [Xlen-1:0] immReg;
    logic [Xlen-1:0] aluA;
    logic [Xlen-1:0] aluB;
    logic [Xlen-1:0] aluOut;
    logic [Xlen-1:0] pcPlus4;
    logic            rdWrite;

    // IR and register file hold still from Decode until the end of Writeback,
    // so these operands settle in Decode and keep their value afterwards
    always_ff @(posedge clk) begin
        rs1Reg <= rs1Data;
        rs2Reg <= rs2Data;
        immReg <= imm;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= aluOut; // Valid from Writeback on
        end
    end

    assign aluA = (ctrl.srcA == SrcAPc) ? pc : rs1Reg;

    always_comb begin
        case (ctrl.srcB)
            SrcBRs2: aluB = rs2Reg;
            SrcBImm: aluB = immReg;
            default: aluB = 32'd4;
        endcase
    end

    always_comb begin
        case (ctrl.aluOp)
            AluSub:  aluOut = aluA - aluB;
            AluAnd:  aluOut = aluA & aluB;
            AluOr:   aluOut = aluA | aluB;
            AluXor:  aluOut = aluA ^ aluB;
            AluSlt:  aluOut = {{(Xlen-1){1'b0}}, $signed(aluA) < $signed(aluB)};
            AluSltu: aluOut = {{(Xlen-1){1'b0}}, aluA < aluB};
            AluSll:  aluOut = aluA << aluB[4:0];
            AluSrl:  aluOut = aluA >> aluB[4:0];
            AluSra:  aluOut = $signed(aluA) >>> aluB[4:0];
            default: aluOut = aluA + aluB;
        endcase
    end

    always_comb begin
        case (instr.funct3)
            F3Beq:   branchTaken = (rs1Reg == rs2Reg);
            F3Bne:   branchTaken = (rs1Reg != rs2Reg);
            F3Blt:   branchTaken = ($signed(rs1Reg) < $signed(rs2Reg));
            F3Bge:   branchTaken = ($signed(rs1Reg) >= $signed(rs2Reg));
            F3Bltu:  branchTaken = (rs1Reg < rs2Reg);
            F3Bgeu:  branchTaken = (rs1Reg >= rs2Reg);
            default: branchTaken = 1'b0;
        endcase
    end

    assign storeData = rs2Reg;
    assign pcPlus4   = pc + 32'd4;

    always_comb begin
        case (ctrl.wbSel)
            WbMem:   wbData = memData;
            WbPc4:   wbData = pcPlus4; // Link address
            default: wbData = result;
        endcase
    end

    assign rdWrite = ctrl.regWrite && (instr.rd != 5'd0); // x0 writes are dropped

    always_comb begin
        commit          = '0;
        commit.valid    = ctrl.commit;
        commit.pc       = pc;
        commit.rdWrite  = rdWrite;
        commit.rd       = rdWrite ? instr.rd : 5'd0;
        commit.rdData   = rdWrite ? wbData : '0;
        commit.memWrite = ctrl.memWrite;
        commit.memAddr  = ctrl.memWrite ? result : '0;
    end

endmodule

//--- rvMulti.sv
`timescale 1ns/100ps

module rvMulti (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                progWrite,
    input  logic [rvCorePkg::MemAddrBits-1:0]   progAddr,
    input  logic [rvCorePkg::Xlen-1:0]          progData,
    output rvCorePkg::commitInfo                commit
);
    import rvIsaPkg::*;
    import rvCorePkg::*;

    ctrlWord         ctrl;
    instrFields      instr;
    logic            branchTaken;
    logic [Xlen-1:0] pc;
    logic [Xlen-1:0] instrWord;
    logic [Xlen-1:0] imm;
    logic [Xlen-1:0] rs1Data;
    logic [Xlen-1:0] rs2Data;
    logic [Xlen-1:0] memData;
    logic [Xlen-1:0] result;
    logic [Xlen-1:0] storeData;
    logic [Xlen-1:0] wbData;

    rvControl iControl (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .branchTaken (branchTaken),
        .ctrl        (ctrl)
    );

    rvFetch iFetch (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .instrWord (instrWord),
        .target    (result),
        .pc        (pc),
        .instr     (instr)
    );

    // Program load only while reset is held
    rvMemory #(.Depth(MemWords)) iMem (
        .clk       (clk),
        .writeEn   (progWrite && reset),
        .writeAddr (progAddr),
        .writeData (progData),
        .readAddr  (pc[MemAddrBits+1:2]),
        .readData  (instrWord)
    );

    rvMemory #(.Depth(MemWords)) dMem (
        .clk       (clk),
        .writeEn   (ctrl.memWrite),
        .writeAddr (result[MemAddrBits+1:2]),
        .writeData (storeData),
        .readAddr  (result[MemAddrBits+1:2]),
        .readData  (memData)
    );

    rvImmGen iImmGen (
        .instr (instr),
        .kind  (ctrl.immKind),
        .imm   (imm)
    );

    rvRegFile iRegFile (
        .clk       (clk),
        .reset     (reset),
        .rs1       (instr.rs1),
        .rs2       (instr.rs2),
        .writeEn   (ctrl.regWrite),
        .rd        (instr.rd),
        .writeData (wbData),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    rvExecute iExecute (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .instr       (instr),
        .pc          (pc),
        .imm         (imm),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .memData     (memData),
        .branchTaken (branchTaken),
        .result      (result),
        .storeData   (storeData),
        .wbData      (wbData),
        .commit      (commit)
    );

endmodule

//--- rvMultiTbProgram.svh
// One entry per retired instruction, in commit order
// Columns: instruction word, expected commit (pc, register or store result)
task automatic fillTable();
    // Immediate forms, x1 = 5 and x2 = -3 from here on
    addEntry(iType(OpImm, F3Add, 1, 0, 5), regResult('h00, 1, 32'h0000_0005));
    addEntry(iType(OpImm, F3Add, 2, 0, -3), regResult('h04, 2, 32'hffff_fffd));
    addEntry(iType(OpImm, F3And, 3, 1, 6), regResult('h08, 3, 32'h0000_0004));
    addEntry(iType(OpImm, F3Or, 4, 1, 'ha), regResult('h0c, 4, 32'h0000_000f));
    addEntry(iType(OpImm, F3Xor, 5, 2, 'hf), regResult('h10, 5, 32'hffff_fff2));
    addEntry(iType(OpImm, F3Slt, 6, 2, 1), regResult('h14, 6, 32'h0000_0001));
    addEntry(iType(OpImm, F3Sltu, 7, 2, 1), regResult('h18, 7, 32'h0000_0000));
    addEntry(iType(OpImm, F3Sll, 8, 1, 4), regResult('h1c, 8, 32'h0000_0050));
    addEntry(iType(OpImm, F3Srl, 9, 2, 28), regResult('h20, 9, 32'h0000_000f));
    addEntry(iType(OpImm, F3Srl, 10, 2, 'h401), regResult('h24, 10, 32'hffff_fffe)); // SRAI
    addEntry(iType(OpImm, F3Add, 0, 1, 7), noResult('h28)); // Write to x0
    addEntry(rType(7'h00, F3Add, 11, 0, 1), regResult('h2c, 11, 32'h0000_0005));

    // Register-register forms
    addEntry(rType(7'h00, F3Add, 12, 1, 2), regResult('h30, 12, 32'h0000_0002));
    addEntry(rType(Funct7Alt, F3Add, 13, 2, 1), regResult('h34, 13, 32'hffff_fff8));
    addEntry(rType(7'h00, F3And, 14, 2, 1), regResult('h38, 14, 32'h0000_0005));
    addEntry(rType(7'h00, F3Or, 15, 2, 1), regResult('h3c, 15, 32'hffff_fffd));
    addEntry(rType(7'h00, F3Xor, 16, 2, 1), regResult('h40, 16, 32'hffff_fff8));
    addEntry(rType(7'h00, F3Slt, 17, 2, 1), regResult('h44, 17, 32'h0000_0001));
    addEntry(rType(7'h00, F3Sltu, 18, 2, 1), regResult('h48, 18, 32'h0000_0000));
    addEntry(rType(7'h00, F3Sll, 19, 1, 1), regResult('h4c, 19, 32'h0000_00a0));
    addEntry(rType(7'h00, F3Srl, 20, 13, 1), regResult('h50, 20, 32'h07ff_ffff));
    addEntry(rType(Funct7Alt, F3Srl, 21, 13, 1), regResult('h54, 21, 32'hffff_ffff));

    // Store then load back
    addEntry(iType(OpImm, F3Add, 22, 0, 'h40), regResult('h58, 22, 32'h0000_0040));
    addEntry(sType(13, 22, 8), storeResult('h5c, 32'h0000_0048));
    addEntry(iType(OpLoad, 3'b010, 23, 22, 8), regResult('h60, 23, 32'hffff_fff8));

    // Branches, a taken one skips the next word
    addEntry(bType(F3Beq, 1, 11, 8), noResult('h64)); // Taken
    addEntry(bType(F3Beq, 1, 2, 8), noResult('h6c));
    addEntry(bType(F3Bne, 1, 2, 8), noResult('h70)); // Taken
    addEntry(bType(F3Bne, 1, 11, 8), noResult('h78));
    addEntry(bType(F3Blt, 2, 1, 8), noResult('h7c)); // Taken
    addEntry(bType(F3Blt, 1, 2, 8), noResult('h84));
    addEntry(bType(F3Bge, 1, 2, 8), noResult('h88)); // Taken
    addEntry(bType(F3Bge, 2, 1, 8), noResult('h90));
    addEntry(bType(F3Bltu, 1, 2, 8), noResult('h94)); // Taken
    addEntry(bType(F3Bltu, 2, 1, 8), noResult('h9c));
    addEntry(bType(F3Bgeu, 2, 1, 8), noResult('ha0)); // Taken
    addEntry(bType(F3Bgeu, 1, 2, 8), noResult('ha8));

    // Jumps, JALR target 0xc9 lands on 0xc8
    addEntry(jType(24, 12), regResult('hac, 24, 32'h0000_00b0));
    addEntry(iType(OpImm, F3Add, 25, 0, 'hc9), regResult('hb8, 25, 32'h0000_00c9));
    addEntry(iType(OpJalr, 3'b000, 26, 25, 0), regResult('hbc, 26, 32'h0000_00c0));
    addEntry(rType(7'h00, F3Add, 27, 26, 24), regResult('hc8, 27, 32'h0000_0170));

    // Unknown opcode retires as a no-op
    addEntry(32'hffff_ffff, noResult('hcc));
    addEntry(rType(7'h00, F3Add, 28, 27, 1), regResult('hd0, 28, 32'h0000_0175));
endtask

//--- rvMultiTb.sv
`timescale 1ns/100ps

module rvMultiTb;
    import rvIsaPkg::*;
    import rvCorePkg::*;

    logic                   clk;
    logic                   reset;
    logic                   progWrite;
    logic [MemAddrBits-1:0] progAddr;
    logic [Xlen-1:0]        progData;
    commitInfo              commit;

    logic [Xlen-1:0] entryWord [MemWords];
    commitInfo       entryExp [MemWords];
    int              entryCount;
    int              entryIdx;
    int              fillAddr;
    int              cycleCount; // Cycles since reset release
    int              cycleLimit;

    rvMulti i_rvMulti (
        .clk       (clk),
        .reset     (reset),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .commit    (commit)
    );

    always #2 clk = ~clk; // 4 ns period

    // Instruction encoders, one per RV32I format
    function automatic logic [31:0] rType(input logic [6:0] funct7, input logic [2:0] funct3,
                                          input int rd, input int rs1, input int rs2);
        return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], OpReg};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] opcode, input logic [2:0] funct3,
                                          input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
    endfunction

    function automatic logic [31:0] sType(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OpStore}; // SW only
    endfunction

    function automatic logic [31:0] bType(input logic [2:0] funct3, input int rs1,
                                          input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3, imm[4:1], imm[11], OpBranch};
    endfunction

    function automatic logic [31:0] jType(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OpJal};
    endfunction

    function automatic commitInfo regResult(input int pc, input int rd, input logic [31:0] data);
        commitInfo c;
        c         = '0;
        c.valid   = 1'b1;
        c.pc      = pc;
        c.rdWrite = 1'b1;
        c.rd      = rd[4:0];
        c.rdData  = data;
        return c;
    endfunction

    function automatic commitInfo storeResult(input int pc, input logic [31:0] addr);
        commitInfo c;
        c          = '0;
        c.valid    = 1'b1;
        c.pc       = pc;
        c.memWrite = 1'b1;
        c.memAddr  = addr;
        return c;
    endfunction

    function automatic commitInfo noResult(input int pc);
        commitInfo c;
        c       = '0;
        c.valid = 1'b1;
        c.pc    = pc;
        return c;
    endfunction

    task automatic addEntry(input logic [31:0] word, input commitInfo exp);
        entryWord[entryCount] = word;
        entryExp[entryCount]  = exp;
        entryCount++;
    endtask

    `include "rvMultiTbProgram.svh"

    task automatic stopRun();
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic valueError(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("ERROR %s at entry %0d: got 0x%h, expected 0x%h", name, entryIdx, got, exp);
        stopRun();
    endtask

    task automatic plainError(input string what);
        $display("%s", what);
        stopRun();
    endtask

    task automatic checkPc(input commitInfo got, input commitInfo exp);
        if (got.pc !== exp.pc) begin
            valueError("commit.pc", got.pc, exp.pc);
        end
    endtask

    task automatic checkRegResult(input commitInfo got, input commitInfo exp);
        if (got.rdWrite !== exp.rdWrite) begin
            valueError("commit.rdWrite", {31'd0, got.rdWrite}, {31'd0, exp.rdWrite});
        end
        if (exp.rdWrite) begin
            if (got.rd !== exp.rd) begin
                valueError("commit.rd", {27'd0, got.rd}, {27'd0, exp.rd});
            end
            if (got.rdData !== exp.rdData) begin
                valueError("commit.rdData", got.rdData, exp.rdData);
            end
        end
    endtask

    task automatic checkStore(input commitInfo got, input commitInfo exp);
        if (got.memWrite !== exp.memWrite) begin
            valueError("commit.memWrite", {31'd0, got.memWrite}, {31'd0, exp.memWrite});
        end
        if (exp.memWrite && got.memAddr !== exp.memAddr) begin
            valueError("commit.memAddr", got.memAddr, exp.memAddr);
        end
    endtask

    // One reset cycle, commit must stay quiet
    task automatic resetCycle();
        @(negedge clk);
        progWrite = 1'b0;
        if (commit.valid !== 1'b0) begin
            plainError("commit.valid went high while reset was held");
        end
    endtask

    task automatic loadWord(input int addr, input logic [31:0] word);
        resetCycle();
        progWrite = 1'b1;
        progAddr  = addr[MemAddrBits-1:0];
        progData  = word;
    endtask

    task automatic nextCycle();
        @(negedge clk);
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            plainError($sformatf("Timeout: commits stopped before cycle %0d", cycleLimit));
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        progWrite  = 1'b0;
        progAddr   = '0;
        progData   = '0;
        entryCount = 0;
        cycleCount = 0;
        fillTable();
        cycleLimit = 4 * entryCount + 20;

        repeat (3) begin
            resetCycle();
        end
        // Unused words hold ADDI x31, x0, wordAddr so a wrong path shows up
        for (fillAddr = 0; fillAddr < MemWords; fillAddr++) begin
            loadWord(fillAddr, iType(OpImm, F3Add, 31, 0, fillAddr));
        end
        for (entryIdx = 0; entryIdx < entryCount; entryIdx++) begin
            loadWord(entryExp[entryIdx].pc >> 2, entryWord[entryIdx]);
        end
        @(negedge clk);
        progWrite = 1'b0;
        reset     = 1'b0; // Cycle 0 is the first Fetch

        for (entryIdx = 0; entryIdx < entryCount; entryIdx++) begin
            nextCycle();
            while (commit.valid !== 1'b1) begin
                nextCycle();
            end
            if (cycleCount != 4 * entryIdx + 3) begin
                plainError($sformatf("Commit %0d came at cycle %0d instead of cycle %0d",
                                     entryIdx, cycleCount, 4 * entryIdx + 3));
            end
            checkPc(commit, entryExp[entryIdx]);
            checkRegResult(commit, entryExp[entryIdx]);
            checkStore(commit, entryExp[entryIdx]);
        end
        repeat (3) begin
            nextCycle();
            if (commit.valid !== 1'b0) begin
                plainError("Commit pulse arrived with no table entry left");
            end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- rvMulti.f
+incdir+.
rvIsaPkg.sv
rvCorePkg.sv
rvMemory.sv
rvImmGen.sv
rvRegFile.sv
rvControl.sv
rvFetch.sv
rvExecute.sv
rvMulti.sv
rvMultiTb.sv

//--- Makefile
TOP = rvMultiTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f rvMulti.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@! grep -q "Simulation failed" sim.log
	@grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f rvMulti.f

clean:
	rm -rf obj_dir sim.log
